//--- design/rbb_cfg.svh
`ifndef RBB_CFG_SVH
`define RBB_CFG_SVH

// identification value, bit 0 must be set
`define RBB_IDCODE 32'h4B17_D0A5

// instruction register
`define RBB_IR_W 4
`define RBB_IR_IDCODE 4'b0001
`define RBB_IR_BYPASS 4'b1111

// tdo sample queue entries
`define RBB_RESP_DEPTH 4

`endif

//--- design/rbb_pkg.sv
`default_nettype none

package rbb_pkg;

    // command classes decoded from one host byte
    typedef enum logic [2:0] {
        CMD_PINS    = 3'd0,
        CMD_RST     = 3'd1,
        CMD_LED_ON  = 3'd2,
        CMD_LED_OFF = 3'd3,
        CMD_READ    = 3'd4,
        CMD_QUIT    = 3'd5,
        CMD_NONE    = 3'd6
    } rbb_cmd_e;

    // IEEE 1149.1 controller states
    typedef enum logic [3:0] {
        TAP_RESET, TAP_IDLE,
        TAP_SEL_DR, TAP_CAP_DR, TAP_SHIFT_DR, TAP_EXIT1_DR,
        TAP_PAUSE_DR, TAP_EXIT2_DR, TAP_UPD_DR,
        TAP_SEL_IR, TAP_CAP_IR, TAP_SHIFT_IR, TAP_EXIT1_IR,
        TAP_PAUSE_IR, TAP_EXIT2_IR, TAP_UPD_IR
    } tap_state_e;

    // four-phase req/ack phases, shared by both channel ends
    typedef enum logic [1:0] {
        HS_IDLE     = 2'd0,
        HS_REQ      = 2'd1,
        HS_WAIT_LOW = 2'd2
    } hs_state_e;

endpackage

`default_nettype wire

//--- design/rbb_cmd_rx.sv
`timescale 1ns/1ps
`default_nettype none

module rbb_cmd_rx import rbb_pkg::*; (
    input  wire logic       clk,
    input  wire logic       rst,
    input  wire logic       cmd_req,
    input  wire logic [7:0] cmd_data,
    output logic            cmd_ack,
    output logic            byte_valid,
    output logic [7:0]      byte_data,
    input  wire logic       byte_take
);

    hs_state_e hs_state;
    logic      capture;

    // accept only when the previous byte has been consumed
    assign capture = (hs_state == HS_IDLE) && cmd_req && !byte_valid;
    assign cmd_ack = (hs_state != HS_IDLE);

    always_ff @(posedge clk) begin
        if (rst) begin
            hs_state   <= HS_IDLE;
            byte_valid <= 1'b0;
        end else begin
            case (hs_state)
                HS_IDLE: begin
                    if (capture) begin
                        hs_state <= HS_REQ;
                    end
                end
                HS_REQ: begin
                    // host released req, drop ack next cycle
                    if (!cmd_req) begin
                        hs_state <= HS_WAIT_LOW;
                    end
                end
                default: begin
                    hs_state <= HS_IDLE;
                end
            endcase

            if (capture) begin
                byte_valid <= 1'b1;
            end else if (byte_take) begin
                byte_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            byte_data <= cmd_data;
        end
    end

endmodule

`default_nettype wire

//--- design/rbb_interp.sv
`timescale 1ns/1ps
`default_nettype none

module rbb_interp import rbb_pkg::*; (
    input  wire logic       clk,
    input  wire logic       rst,
    input  wire logic       byte_valid,
    input  wire logic [7:0] byte_data,
    output logic            byte_take,
    input  wire logic       full,
    input  wire logic       tdo,
    output logic            tck,
    output logic            tms,
    output logic            tdi,
    output logic            trst,
    output logic            srst,
    output logic            led,
    output logic            bit_push,
    output logic            bit_val
);

    rbb_cmd_e   cmd;
    logic [7:0] pin_code;
    logic [7:0] rst_code;

    // offsets from the first byte of each command range
    assign pin_code = byte_data - "0";
    assign rst_code = byte_data - "r";

    always_comb begin
        if (byte_data >= "0" && byte_data <= "7") begin
            cmd = CMD_PINS;
        end else if (byte_data >= "r" && byte_data <= "u") begin
            cmd = CMD_RST;
        end else if (byte_data == "B") begin
            cmd = CMD_LED_ON;
        end else if (byte_data == "b") begin
            cmd = CMD_LED_OFF;
        end else if (byte_data == "R") begin
            cmd = CMD_READ;
        end else if (byte_data == "Q") begin
            cmd = CMD_QUIT;
        end else begin
            cmd = CMD_NONE;
        end
    end

    // a read has to wait for room in the response queue
    assign byte_take = byte_valid && !((cmd == CMD_READ) && full);

    // tdo is sampled at the edge that consumes the read
    assign bit_push = byte_take && (cmd == CMD_READ);
    assign bit_val  = tdo;

    always_ff @(posedge clk) begin
        if (rst) begin
            tck  <= 1'b0;
            tms  <= 1'b1;
            tdi  <= 1'b1;
            trst <= 1'b1;
            srst <= 1'b1;
            led  <= 1'b0;
        end else if (byte_take) begin
            case (cmd)
                CMD_PINS: begin
                    {tck, tms, tdi} <= pin_code[2:0];
                end
                CMD_RST: begin
                    {trst, srst} <= rst_code[1:0];
                end
                CMD_LED_ON: begin
                    led <= 1'b1;
                end
                CMD_LED_OFF: begin
                    led <= 1'b0;
                end
                // quit, read and unknown bytes leave the pins alone
                default: begin
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- design/rbb_resp_tx.sv
`timescale 1ns/1ps
`default_nettype none

`include "rbb_cfg.svh"

module rbb_resp_tx import rbb_pkg::*; (
    input  wire logic       clk,
    input  wire logic       rst,
    input  wire logic       bit_push,
    input  wire logic       bit_val,
    output logic            full,
    output logic            resp_req,
    output logic [7:0]      resp_data,
    input  wire logic       resp_ack
);

    localparam int PTR_W = $clog2(`RBB_RESP_DEPTH);
    localparam int CNT_W = $clog2(`RBB_RESP_DEPTH + 1);

    logic [`RBB_RESP_DEPTH-1:0] q_mem;
    logic [PTR_W-1:0]           wr_ptr;
    logic [PTR_W-1:0]           rd_ptr;
    logic [CNT_W-1:0]           count;
    hs_state_e                  hs_state;
    logic                       push_ok;
    logic                       pop;
    logic                       launch;

    assign full     = (count == CNT_W'(`RBB_RESP_DEPTH));
    assign push_ok  = bit_push && !full;
    assign launch   = (hs_state == HS_IDLE) && (count != '0);
    // head leaves once the host has acknowledged it
    assign pop      = (hs_state == HS_REQ) && resp_ack;
    assign resp_req = (hs_state == HS_REQ);

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            hs_state <= HS_IDLE;
        end else begin
            if (push_ok) begin
                wr_ptr <= (wr_ptr == PTR_W'(`RBB_RESP_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(`RBB_RESP_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push_ok, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase

            case (hs_state)
                HS_IDLE: begin
                    if (launch) begin
                        hs_state <= HS_REQ;
                    end
                end
                HS_REQ: begin
                    if (resp_ack) begin
                        hs_state <= HS_WAIT_LOW;
                    end
                end
                default: begin
                    // no new req until the host drops ack
                    if (!resp_ack) begin
                        hs_state <= HS_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push_ok) begin
            q_mem[wr_ptr] <= bit_val;
        end
    end

    // ascii byte held stable for the whole request
    always_ff @(posedge clk) begin
        if (launch) begin
            resp_data <= q_mem[rd_ptr] ? "1" : "0";
        end
    end

endmodule

`default_nettype wire

//--- design/jtag_tap.sv
`timescale 1ns/1ps
`default_nettype none

`include "rbb_cfg.svh"

module jtag_tap import rbb_pkg::*; (
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic tck,
    input  wire logic tms,
    input  wire logic tdi,
    input  wire logic trst,
    output logic      tdo
);

    tap_state_e          state;
    logic                tck_q;
    logic                tck_rise;
    logic                tck_fall;
    logic [`RBB_IR_W-1:0] ir;
    logic [`RBB_IR_W-1:0] ir_sr;
    logic [31:0]         id_sr;
    logic                byp_sr;
    logic                sel_idcode;

    function automatic tap_state_e tap_next(input tap_state_e s, input logic m);
        case (s)
            TAP_RESET:    return m ? TAP_RESET  : TAP_IDLE;
            TAP_IDLE:     return m ? TAP_SEL_DR : TAP_IDLE;
            TAP_SEL_DR:   return m ? TAP_SEL_IR : TAP_CAP_DR;
            TAP_CAP_DR:   return m ? TAP_EXIT1_DR : TAP_SHIFT_DR;
            TAP_SHIFT_DR: return m ? TAP_EXIT1_DR : TAP_SHIFT_DR;
            TAP_EXIT1_DR: return m ? TAP_UPD_DR : TAP_PAUSE_DR;
            TAP_PAUSE_DR: return m ? TAP_EXIT2_DR : TAP_PAUSE_DR;
            TAP_EXIT2_DR: return m ? TAP_UPD_DR : TAP_SHIFT_DR;
            TAP_UPD_DR:   return m ? TAP_SEL_DR : TAP_IDLE;
            TAP_SEL_IR:   return m ? TAP_RESET  : TAP_CAP_IR;
            TAP_CAP_IR:   return m ? TAP_EXIT1_IR : TAP_SHIFT_IR;
            TAP_SHIFT_IR: return m ? TAP_EXIT1_IR : TAP_SHIFT_IR;
            TAP_EXIT1_IR: return m ? TAP_UPD_IR : TAP_PAUSE_IR;
            TAP_PAUSE_IR: return m ? TAP_EXIT2_IR : TAP_PAUSE_IR;
            TAP_EXIT2_IR: return m ? TAP_UPD_IR : TAP_SHIFT_IR;
            default:      return m ? TAP_SEL_DR : TAP_IDLE;
        endcase
    endfunction

    // tck is just another input sampled on clk
    assign tck_rise = tck && !tck_q;
    assign tck_fall = !tck && tck_q;

    // anything other than IDCODE, BYPASS included, selects the bypass bit
    assign sel_idcode = (ir == `RBB_IR_IDCODE);

    always_ff @(posedge clk) begin
        if (rst || !trst) begin
            state <= TAP_RESET;
            ir    <= `RBB_IR_IDCODE;
            tck_q <= 1'b0;
            tdo   <= 1'b0;
        end else begin
            tck_q <= tck;
            if (tck_rise) begin
                state <= tap_next(state, tms);
                if (state == TAP_RESET) begin
                    ir <= `RBB_IR_IDCODE;
                end else if (state == TAP_UPD_IR) begin
                    ir <= ir_sr;
                end
            end
            if (tck_fall) begin
                case (state)
                    TAP_SHIFT_IR: tdo <= ir_sr[0];
                    TAP_SHIFT_DR: tdo <= sel_idcode ? id_sr[0] : byp_sr;
                    default:      tdo <= 1'b0;
                endcase
            end
        end
    end

    // shift registers, loaded in capture and shifted lsb first
    always_ff @(posedge clk) begin
        if (tck_rise) begin
            case (state)
                TAP_CAP_IR: begin
                    ir_sr <= `RBB_IR_W'(4'b0001);
                end
                TAP_SHIFT_IR: begin
                    ir_sr <= {tdi, ir_sr[`RBB_IR_W-1:1]};
                end
                TAP_CAP_DR: begin
                    id_sr  <= `RBB_IDCODE;
                    byp_sr <= 1'b0;
                end
                TAP_SHIFT_DR: begin
                    if (sel_idcode) begin
                        id_sr <= {tdi, id_sr[31:1]};
                    end else begin
                        byp_sr <= tdi;
                    end
                end
                default: begin
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- design/rbb_jtag_top.sv
`timescale 1ns/1ps
`default_nettype none

module rbb_jtag_top (
    input  wire logic       clk,
    input  wire logic       rst,
    input  wire logic       cmd_req,
    input  wire logic [7:0] cmd_data,
    output logic            cmd_ack,
    output logic            resp_req,
    output logic [7:0]      resp_data,
    input  wire logic       resp_ack,
    output logic            led,
    output logic            trst,
    output logic            srst
);

    logic       byte_valid;
    logic [7:0] byte_data;
    logic       byte_take;
    logic       full;
    logic       bit_push;
    logic       bit_val;
    logic       tck;
    logic       tms;
    logic       tdi;
    logic       tdo;

    rbb_cmd_rx i_rbb_cmd_rx (
        .clk        (clk),
        .rst        (rst),
        .cmd_req    (cmd_req),
        .cmd_data   (cmd_data),
        .cmd_ack    (cmd_ack),
        .byte_valid (byte_valid),
        .byte_data  (byte_data),
        .byte_take  (byte_take)
    );

    rbb_interp i_rbb_interp (
        .clk        (clk),
        .rst        (rst),
        .byte_valid (byte_valid),
        .byte_data  (byte_data),
        .byte_take  (byte_take),
        .full       (full),
        .tdo        (tdo),
        .tck        (tck),
        .tms        (tms),
        .tdi        (tdi),
        .trst       (trst),
        .srst       (srst),
        .led        (led),
        .bit_push   (bit_push),
        .bit_val    (bit_val)
    );

    rbb_resp_tx i_rbb_resp_tx (
        .clk        (clk),
        .rst        (rst),
        .bit_push   (bit_push),
        .bit_val    (bit_val),
        .full       (full),
        .resp_req   (resp_req),
        .resp_data  (resp_data),
        .resp_ack   (resp_ack)
    );

    // on-chip target so that tdo returns real scan data
    jtag_tap i_jtag_tap (
        .clk        (clk),
        .rst        (rst),
        .tck        (tck),
        .tms        (tms),
        .tdi        (tdi),
        .trst       (trst),
        .tdo        (tdo)
    );

endmodule

`default_nettype wire

//--- bench/tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // reset held for 16 rising edges
    initial begin
        rst = 1'b1;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

`default_nettype wire

//--- bench/rbb_jtag_assert.sv
`timescale 1ns/1ps
`default_nettype none

module rbb_jtag_assert (
    input wire logic       clk,
    input wire logic       rst,
    input wire logic       cmd_req,
    input wire logic [7:0] cmd_data,
    input wire logic       cmd_ack,
    input wire logic       resp_req,
    input wire logic [7:0] resp_data,
    input wire logic       resp_ack
);

    // command channel ordering
    assert property (@(posedge clk) disable iff (rst) $rose(cmd_ack) |-> $past(cmd_req))
        else $error("cmd_ack rose without cmd_req");
    assert property (@(posedge clk) disable iff (rst) $fell(cmd_ack) |-> !cmd_req)
        else $error("cmd_ack fell while cmd_req high");

    // response channel ordering
    assert property (@(posedge clk) disable iff (rst) $rose(resp_ack) |-> resp_req)
        else $error("resp_ack rose without resp_req");
    assert property (@(posedge clk) disable iff (rst) $rose(resp_req) |-> !resp_ack)
        else $error("resp_req rose while resp_ack high");

    // data held while req stays high
    assert property (@(posedge clk) disable iff (rst)
        cmd_req && $past(cmd_req) |-> $stable(cmd_data))
        else $error("cmd_data changed during request");
    assert property (@(posedge clk) disable iff (rst)
        resp_req && $past(resp_req) |-> $stable(resp_data))
        else $error("resp_data changed during request");

    assert property (@(posedge clk) $past(rst) |-> !cmd_ack && !resp_req)
        else $error("handshake outputs not low after reset");

endmodule

bind rbb_jtag_top rbb_jtag_assert i_rbb_jtag_assert (
    .clk       (clk),
    .rst       (rst),
    .cmd_req   (cmd_req),
    .cmd_data  (cmd_data),
    .cmd_ack   (cmd_ack),
    .resp_req  (resp_req),
    .resp_data (resp_data),
    .resp_ack  (resp_ack)
);

`default_nettype wire

//--- bench/rbb_jtag_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "rbb_cfg.svh"

module rbb_jtag_tb import rbb_pkg::*; ();

    localparam int TIMEOUT = 200;

    logic       clk;
    logic       rst;
    logic       cmd_req;
    logic [7:0] cmd_data;
    logic       resp_ack;
    wire        cmd_ack;
    wire        resp_req;
    wire  [7:0] resp_data;
    wire        led;
    wire        trst;
    wire        srst;

    logic [7:0] obs_q[$];
    logic [7:0] exp_q[$];
    logic       resp_pause;
    integer     seed;
    int         errors;
    int         tests_run;
    int         tests_failed;
    int         test_start_errors;

    // host-side view of the pins and the TAP
    logic        m_tck;
    logic        m_tms;
    logic        m_tdi;
    logic        m_trst;
    logic        m_srst;
    logic        m_led;
    logic        m_tck_q;
    logic        m_tdo;
    logic        m_byp;
    logic [3:0]  m_ir;
    logic [3:0]  m_ir_sr;
    logic [31:0] m_id_sr;
    tap_state_e  m_state;

    tb_clk_gen i_tb_clk_gen (
        .clk (clk),
        .rst (rst)
    );

    rbb_jtag_top i_rbb_jtag_top (
        .clk       (clk),
        .rst       (rst),
        .cmd_req   (cmd_req),
        .cmd_data  (cmd_data),
        .cmd_ack   (cmd_ack),
        .resp_req  (resp_req),
        .resp_data (resp_data),
        .resp_ack  (resp_ack),
        .led       (led),
        .trst      (trst),
        .srst      (srst)
    );

    function tap_state_e next_state(input tap_state_e s, input logic t);
        case (s)
            TAP_RESET:    next_state = t ? TAP_RESET : TAP_IDLE;
            TAP_IDLE:     next_state = t ? TAP_SEL_DR : TAP_IDLE;
            TAP_SEL_DR:   next_state = t ? TAP_SEL_IR : TAP_CAP_DR;
            TAP_CAP_DR:   next_state = t ? TAP_EXIT1_DR : TAP_SHIFT_DR;
            TAP_SHIFT_DR: next_state = t ? TAP_EXIT1_DR : TAP_SHIFT_DR;
            TAP_EXIT1_DR: next_state = t ? TAP_UPD_DR : TAP_PAUSE_DR;
            TAP_PAUSE_DR: next_state = t ? TAP_EXIT2_DR : TAP_PAUSE_DR;
            TAP_EXIT2_DR: next_state = t ? TAP_UPD_DR : TAP_SHIFT_DR;
            TAP_SEL_IR:   next_state = t ? TAP_RESET : TAP_CAP_IR;
            TAP_CAP_IR:   next_state = t ? TAP_EXIT1_IR : TAP_SHIFT_IR;
            TAP_SHIFT_IR: next_state = t ? TAP_EXIT1_IR : TAP_SHIFT_IR;
            TAP_EXIT1_IR: next_state = t ? TAP_UPD_IR : TAP_PAUSE_IR;
            TAP_PAUSE_IR: next_state = t ? TAP_EXIT2_IR : TAP_PAUSE_IR;
            TAP_EXIT2_IR: next_state = t ? TAP_UPD_IR : TAP_SHIFT_IR;
            default:      next_state = t ? TAP_SEL_DR : TAP_IDLE;
        endcase
    endfunction

    // steps the reference model by one command byte and returns the tdo a read would see
    function logic ref_step(input logic [7:0] b);
        logic [7:0] ofs;
        ofs = b - 8'h72;
        if (b >= "0" && b <= "7") begin
            {m_tck, m_tms, m_tdi} = b[2:0];
        end else if (b >= "r" && b <= "u") begin
            {m_trst, m_srst} = ofs[1:0];
        end else if (b == "B") begin
            m_led = 1'b1;
        end else if (b == "b") begin
            m_led = 1'b0;
        end
        if (!m_trst) begin
            m_state = TAP_RESET;
            m_ir    = `RBB_IR_IDCODE;
            m_tck_q = 1'b0;
            m_tdo   = 1'b0;
        end else begin
            if (m_tck && !m_tck_q) begin
                case (m_state)
                    TAP_CAP_IR:   m_ir_sr = 4'b0001;
                    TAP_SHIFT_IR: m_ir_sr = {m_tdi, m_ir_sr[3:1]};
                    TAP_UPD_IR:   m_ir = m_ir_sr;
                    TAP_RESET:    m_ir = `RBB_IR_IDCODE;
                    TAP_CAP_DR: begin
                        m_id_sr = `RBB_IDCODE;
                        m_byp   = 1'b0;
                    end
                    TAP_SHIFT_DR: begin
                        if (m_ir == `RBB_IR_IDCODE) begin
                            m_id_sr = {m_tdi, m_id_sr[31:1]};
                        end else begin
                            m_byp = m_tdi;
                        end
                    end
                    default: begin
                    end
                endcase
                m_state = next_state(m_state, m_tms);
            end else if (!m_tck && m_tck_q) begin
                if (m_state == TAP_SHIFT_IR) begin
                    m_tdo = m_ir_sr[0];
                end else if (m_state == TAP_SHIFT_DR) begin
                    m_tdo = (m_ir == `RBB_IR_IDCODE) ? m_id_sr[0] : m_byp;
                end else begin
                    m_tdo = 1'b0;
                end
            end
            m_tck_q = m_tck;
        end
        return m_tdo;
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error: %s got 0x%0h expected 0x%0h", name, got, exp);
            errors++;
        end
    endtask

    task automatic wait_cmd_ack(input logic level);
        int n;
        for (n = 0; n < TIMEOUT; n++) begin
            @(posedge clk);
            if (cmd_ack === level) begin
                break;
            end
        end
        if (n == TIMEOUT) begin
            $display("timeout: cmd_ack did not go to %0d", level);
            errors++;
        end
    endtask

    task automatic start_cmd(input logic [7:0] b, output logic bit_exp);
        wait_cmd_ack(1'b0);
        cmd_data <= b;
        cmd_req  <= 1'b1;
        bit_exp = ref_step(b);
        if (b == "R") begin
            exp_q.push_back(bit_exp ? "1" : "0");
        end
    endtask

    task automatic finish_cmd();
        wait_cmd_ack(1'b1);
        cmd_req <= 1'b0;
        wait_cmd_ack(1'b0);
    endtask

    task automatic send_cmd(input logic [7:0] b, output logic bit_exp);
        start_cmd(b, bit_exp);
        finish_cmd();
    endtask

    // one tck cycle with an optional tdo read before the rise
    task automatic clock_tap(input logic t, input logic d, input logic rd, output logic bit_exp);
        logic unused;
        send_cmd(8'h30 | {5'd0, 1'b0, t, d}, unused);
        bit_exp = 1'b0;
        if (rd) begin
            send_cmd("R", bit_exp);
        end
        send_cmd(8'h30 | {5'd0, 1'b1, t, d}, unused);
    endtask

    task automatic check_ports();
        check("led", 32'(led), 32'(m_led));
        check("trst", 32'(trst), 32'(m_trst));
        check("srst", 32'(srst), 32'(m_srst));
        check("tck", 32'(i_rbb_jtag_top.tck), 32'(m_tck));
        check("tms", 32'(i_rbb_jtag_top.tms), 32'(m_tms));
        check("tdi", 32'(i_rbb_jtag_top.tdi), 32'(m_tdi));
    endtask

    task automatic wait_drain();
        int n;
        for (n = 0; n < TIMEOUT * 4; n++) begin
            @(posedge clk);
            if (exp_q.size() == 0 && obs_q.size() == 0 && !resp_req) begin
                break;
            end
        end
        if (n == TIMEOUT * 4) begin
            $display("timeout: %0d responses never arrived", exp_q.size());
            errors++;
        end
    endtask

    task automatic begin_test();
        test_start_errors = errors;
        tests_run++;
    endtask

    task automatic end_test(input string name);
        wait_drain();
        if (errors == test_start_errors) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: FAIL", tests_run, name);
        end
    endtask

    // walk from reset into Shift-DR and read the 32-bit register
    task automatic read_dr32(output logic [31:0] word);
        logic b;
        clock_tap(1'b0, 1'b0, 1'b0, b);
        clock_tap(1'b1, 1'b0, 1'b0, b);
        clock_tap(1'b0, 1'b0, 1'b0, b);
        clock_tap(1'b0, 1'b0, 1'b0, b);
        for (int i = 0; i < 32; i++) begin
            clock_tap(i == 31, 1'b0, 1'b1, b);
            word[i] = b;
        end
        clock_tap(1'b1, 1'b0, 1'b0, b);
        clock_tap(1'b0, 1'b0, 1'b0, b);
    endtask

    // host side of the response channel
    always @(posedge clk) begin
        if (!rst) begin
            if (!resp_ack && resp_req && !resp_pause) begin
                obs_q.push_back(resp_data);
                resp_ack <= 1'b1;
            end else if (resp_ack && !resp_req) begin
                resp_ack <= 1'b0;
            end
        end
    end

    // compare observed responses against the model
    always @(posedge clk) begin
        while (obs_q.size() > 0 && exp_q.size() > 0) begin
            check("resp_data", 32'(obs_q.pop_front()), 32'(exp_q.pop_front()));
        end
    end

    initial begin
        #1ms;
        $display("watchdog expired before the tests finished");
        $display("sim failed");
        $finish;
    end

    initial begin
        logic        b;
        logic        prev;
        logic [31:0] word;
        int          n;
        cmd_req = 1'b0;
        cmd_data = 8'h00;
        resp_ack = 1'b0;
        resp_pause = 1'b0;
        seed = 96;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        {m_tck, m_tms, m_tdi, m_trst, m_srst, m_led} = 6'b011110;
        m_tck_q = 1'b0;
        m_tdo = 1'b0;
        m_state = TAP_RESET;
        m_ir = `RBB_IR_IDCODE;
        for (n = 0; n < TIMEOUT; n++) begin
            @(posedge clk);
            if (!rst) begin
                break;
            end
        end
        if (n == TIMEOUT) begin
            $display("timeout: reset never released");
            errors++;
        end

        begin_test();
        check_ports();
        send_cmd("B", b);
        check_ports();
        send_cmd("Q", b);
        check_ports();
        send_cmd("z", b);
        check_ports();
        send_cmd("b", b);
        check_ports();
        end_test("led and ignored bytes");

        begin_test();
        for (int c = 0; c < 4; c++) begin
            send_cmd(8'h72 + 8'(c), b);
            check("trst", 32'(trst), 32'(c[1]));
            check("srst", 32'(srst), 32'(c[0]));
        end
        end_test("reset pins");

        begin_test();
        for (int i = 0; i < 5; i++) begin
            clock_tap(1'b1, 1'b0, 1'b0, b);
        end
        read_dr32(word);
        check("idcode", word, `RBB_IDCODE);
        end_test("idcode read");

        begin_test();
        clock_tap(1'b1, 1'b0, 1'b0, b);
        clock_tap(1'b1, 1'b0, 1'b0, b);
        clock_tap(1'b0, 1'b0, 1'b0, b);
        clock_tap(1'b0, 1'b0, 1'b0, b);
        for (int i = 0; i < 4; i++) begin
            clock_tap(i == 3, 1'b1, 1'b0, b);
        end
        clock_tap(1'b1, 1'b0, 1'b0, b);
        clock_tap(1'b0, 1'b0, 1'b0, b);
        clock_tap(1'b1, 1'b0, 1'b0, b);
        clock_tap(1'b0, 1'b0, 1'b0, b);
        clock_tap(1'b0, 1'b0, 1'b0, b);
        prev = 1'b0;
        for (int i = 0; i < 16; i++) begin
            logic d;
            d = 1'($random(seed));
            clock_tap(i == 15, d, 1'b1, b);
            check("bypass bit", 32'(b), 32'(prev));
            prev = d;
        end
        clock_tap(1'b1, 1'b0, 1'b0, b);
        clock_tap(1'b0, 1'b0, 1'b0, b);
        end_test("bypass");

        begin_test();
        resp_pause <= 1'b1;
        for (int i = 0; i < `RBB_RESP_DEPTH + 1; i++) begin
            send_cmd("R", b);
        end
        start_cmd("R", b);
        prev = 1'b0;
        repeat (20) begin
            @(posedge clk);
            prev = prev | cmd_ack;
        end
        check("cmd_ack while full", 32'(prev), 32'd0);
        check("responses while paused", obs_q.size(), 0);
        resp_pause <= 1'b0;
        finish_cmd();
        for (int i = `RBB_RESP_DEPTH + 2; i < 8; i++) begin
            send_cmd("R", b);
        end
        end_test("back-pressure");

        begin_test();
        clock_tap(1'b1, 1'b0, 1'b0, b);
        clock_tap(1'b0, 1'b0, 1'b0, b);
        clock_tap(1'b0, 1'b0, 1'b0, b);
        clock_tap(1'b0, 1'b1, 1'b1, b);
        clock_tap(1'b0, 1'b1, 1'b1, b);
        send_cmd("0", b);
        send_cmd("s", b);
        send_cmd("u", b);
        read_dr32(word);
        check("idcode after trst", word, `RBB_IDCODE);
        end_test("trst mid-shift");

        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+design
design/rbb_pkg.sv
design/rbb_cmd_rx.sv
design/rbb_interp.sv
design/rbb_resp_tx.sv
design/jtag_tap.sv
design/rbb_jtag_top.sv
bench/tb_clk_gen.sv
bench/rbb_jtag_assert.sv
bench/rbb_jtag_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")"

verilator --binary --timing --assert -f filelist.f --top-module rbb_jtag_tb -o rbb_jtag_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/rbb_jtag_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulator exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "sim passed"; then
    exit 0
fi
exit 1
